// ==== hw/exec_pkg.sv ====
// Shared definitions for the execution unit
//   op_t     opcode enum for ALU and index operations
//   state_t  handshake controller states
//   flag bit positions in the NV-BDIZC byte, default data width

package exec_pkg;

   // data width used when the top level does not override it
   parameter int DEFAULT_DATA_W = 8;

   // flag positions, NV-BDIZC layout
   parameter int FLAG_N = 7;
   parameter int FLAG_V = 6;
   parameter int FLAG_Z = 1;
   parameter int FLAG_C = 0;

   typedef enum logic [4:0] {
      // loads from the operand
      OP_LDA,
      OP_LDX,
      OP_LDY,
      // arithmetic and logic against A
      OP_ADC,
      OP_SBC,
      OP_AND,
      OP_ORA,
      OP_EOR,
      OP_CMP,
      // shifts and rotates, A only
      OP_ASL,
      OP_LSR,
      OP_ROL,
      OP_ROR,
      // index increment and decrement
      OP_INX,
      OP_INY,
      OP_DEX,
      OP_DEY,
      // register transfers
      OP_TAX,
      OP_TAY,
      OP_TXA,
      OP_TYA,
      // flag ops
      OP_CLC,
      OP_SEC,
      OP_CLV,
      // indexed effective address
      OP_IDX_X,
      OP_IDX_Y
   } op_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_EXEC,
      ST_WAIT_ADDR,
      ST_DONE
   } state_t;

endpackage

// ==== hw/alu_core.sv ====
// Combinational ALU
// result, next flags and register write enables for one operation

module alu_core #(
   parameter int DATA_W = exec_pkg::DEFAULT_DATA_W
) (
   input  exec_pkg::op_t     op,
   input  logic [DATA_W-1:0] operand,
   input  logic [DATA_W-1:0] a,
   input  logic [DATA_W-1:0] x,
   input  logic [DATA_W-1:0] y,
   input  logic [7:0]        flags,
   output logic [DATA_W-1:0] result,
   output logic [7:0]        flags_next,
   output logic              write_a,
   output logic              write_x,
   output logic              write_y
);

   localparam int MSB = DATA_W - 1;

   logic [DATA_W-1:0] addend;
   logic              carry_in;
   logic [DATA_W:0]   sum;
   logic              overflow;
   logic              set_nz;

   // one adder serves ADC, SBC and CMP
   always_comb begin
      case (op)
         exec_pkg::OP_SBC, exec_pkg::OP_CMP: addend = ~operand;
         default: addend = operand;
      endcase
      // compare always subtracts with borrow clear
      carry_in = (op == exec_pkg::OP_CMP) ? 1'b1 : flags[exec_pkg::FLAG_C];
      sum = {1'b0, a} + {1'b0, addend} + {{DATA_W{1'b0}}, carry_in};
      // same input signs, different result sign
      overflow = (a[MSB] == addend[MSB]) && (sum[MSB] != a[MSB]);
   end

   always_comb begin
      result = a;
      flags_next = flags;
      write_a = 1'b0;
      write_x = 1'b0;
      write_y = 1'b0;
      set_nz = 1'b0;

      case (op)
         exec_pkg::OP_LDA: begin
            result = operand;
            write_a = 1'b1;
            set_nz = 1'b1;
         end
         exec_pkg::OP_LDX: begin
            result = operand;
            write_x = 1'b1;
            set_nz = 1'b1;
         end
         exec_pkg::OP_LDY: begin
            result = operand;
            write_y = 1'b1;
            set_nz = 1'b1;
         end
         exec_pkg::OP_ADC, exec_pkg::OP_SBC: begin
            result = sum[MSB:0];
            write_a = 1'b1;
            set_nz = 1'b1;
            flags_next[exec_pkg::FLAG_C] = sum[DATA_W];
            flags_next[exec_pkg::FLAG_V] = overflow;
         end
         exec_pkg::OP_AND: begin
            result = a & operand;
            write_a = 1'b1;
            set_nz = 1'b1;
         end
         exec_pkg::OP_ORA: begin
            result = a | operand;
            write_a = 1'b1;
            set_nz = 1'b1;
         end
         exec_pkg::OP_EOR: begin
            result = a ^ operand;
            write_a = 1'b1;
            set_nz = 1'b1;
         end
         exec_pkg::OP_CMP: begin
            // difference only feeds the flags
            result = sum[MSB:0];
            set_nz = 1'b1;
            flags_next[exec_pkg::FLAG_C] = sum[DATA_W];
         end
         exec_pkg::OP_ASL, exec_pkg::OP_ROL: begin
            result = {a[MSB-1:0], (op == exec_pkg::OP_ROL) & flags[exec_pkg::FLAG_C]};
            write_a = 1'b1;
            set_nz = 1'b1;
            flags_next[exec_pkg::FLAG_C] = a[MSB];
         end
         exec_pkg::OP_LSR, exec_pkg::OP_ROR: begin
            result = {(op == exec_pkg::OP_ROR) & flags[exec_pkg::FLAG_C], a[MSB:1]};
            write_a = 1'b1;
            set_nz = 1'b1;
            flags_next[exec_pkg::FLAG_C] = a[0];
         end
         exec_pkg::OP_INX, exec_pkg::OP_DEX: begin
            result = (op == exec_pkg::OP_INX) ? x + 1'b1 : x - 1'b1;
            write_x = 1'b1;
            set_nz = 1'b1;
         end
         exec_pkg::OP_INY, exec_pkg::OP_DEY: begin
            result = (op == exec_pkg::OP_INY) ? y + 1'b1 : y - 1'b1;
            write_y = 1'b1;
            set_nz = 1'b1;
         end
         exec_pkg::OP_TAX, exec_pkg::OP_TAY: begin
            result = a;
            write_x = (op == exec_pkg::OP_TAX);
            write_y = (op == exec_pkg::OP_TAY);
            set_nz = 1'b1;
         end
         exec_pkg::OP_TXA, exec_pkg::OP_TYA: begin
            result = (op == exec_pkg::OP_TXA) ? x : y;
            write_a = 1'b1;
            set_nz = 1'b1;
         end
         exec_pkg::OP_CLC: flags_next[exec_pkg::FLAG_C] = 1'b0;
         exec_pkg::OP_SEC: flags_next[exec_pkg::FLAG_C] = 1'b1;
         exec_pkg::OP_CLV: flags_next[exec_pkg::FLAG_V] = 1'b0;
         // index ops touch no register and no flag
         default: result = a;
      endcase

      if (set_nz) begin
         flags_next[exec_pkg::FLAG_N] = result[MSB];
         flags_next[exec_pkg::FLAG_Z] = (result == '0);
      end
   end

endmodule

// ==== hw/index_addr_gen.sv ====
// Indexed address generator
// low byte add first, high byte fixed up only on a page cross

module index_addr_gen #(
   parameter int DATA_W = exec_pkg::DEFAULT_DATA_W
) (
   input  logic                clock,
   input  logic                nreset,
   input  logic                addr_start,
   input  exec_pkg::op_t       op,
   input  logic [2*DATA_W-1:0] base_addr,
   input  logic [DATA_W-1:0]   x,
   input  logic [DATA_W-1:0]   y,
   output logic                addr_done,
   output logic [2*DATA_W-1:0] sum_addr,
   output logic                crossed
);

   typedef enum logic [1:0] {
      AG_IDLE,
      AG_LOW,
      AG_HIGH
   } ag_state_t;

   ag_state_t         state;
   logic [DATA_W-1:0] index;
   logic [DATA_W:0]   low_sum;
   logic [DATA_W-1:0] low_q;
   logic [DATA_W-1:0] high_q;
   logic              carry_q;

   assign index = (op == exec_pkg::OP_IDX_X) ? x : y;
   assign low_sum = {1'b0, base_addr[DATA_W-1:0]} + {1'b0, index};

   // sequencer, extra step only when the low add carried
   always_ff @(posedge clock) begin
      if (nreset) begin
         state <= AG_IDLE;
      end else begin
         case (state)
            AG_IDLE: if (addr_start) state <= AG_LOW;
            AG_LOW:  state <= carry_q ? AG_HIGH : AG_IDLE;
            default: state <= AG_IDLE;
         endcase
      end
   end

   // low sum, carry and high byte
   always_ff @(posedge clock) begin
      if (state == AG_IDLE && addr_start) begin
         low_q <= low_sum[DATA_W-1:0];
         carry_q <= low_sum[DATA_W];
         high_q <= base_addr[2*DATA_W-1:DATA_W];
      end else if (state == AG_LOW && carry_q) begin
         high_q <= high_q + 1'b1;
      end
   end

   assign addr_done = (state == AG_LOW && !carry_q) || (state == AG_HIGH);
   assign sum_addr = {high_q, low_q};
   assign crossed = carry_q;

endmodule

// ==== hw/register_commit.sv ====
// Architectural registers and handshake controller
// captures a request, commits ALU or address results, drives ack

module register_commit #(
   parameter int DATA_W = exec_pkg::DEFAULT_DATA_W
) (
   input  logic                clock,
   input  logic                nreset,
   input  logic                req,
   input  exec_pkg::op_t       op,
   input  logic [DATA_W-1:0]   operand,
   input  logic [2*DATA_W-1:0] base_addr,
   input  logic [DATA_W-1:0]   result,
   input  logic [7:0]          flags_next,
   input  logic                write_a,
   input  logic                write_x,
   input  logic                write_y,
   input  logic                addr_done,
   input  logic [2*DATA_W-1:0] sum_addr,
   input  logic                crossed,
   output logic                ack,
   output exec_pkg::op_t       op_q,
   output logic [DATA_W-1:0]   operand_q,
   output logic [2*DATA_W-1:0] base_q,
   output logic                addr_start,
   output logic [DATA_W-1:0]   a,
   output logic [DATA_W-1:0]   x,
   output logic [DATA_W-1:0]   y,
   output logic [7:0]          flags,
   output logic [2*DATA_W-1:0] eff_addr,
   output logic                page_crossed
);

   exec_pkg::state_t state;
   logic             is_idx;

   assign is_idx = (op_q == exec_pkg::OP_IDX_X) || (op_q == exec_pkg::OP_IDX_Y);

   // one-cycle start, only in ST_EXEC
   assign addr_start = (state == exec_pkg::ST_EXEC) && is_idx;

   // request copy, requester may change inputs afterwards
   always_ff @(posedge clock) begin
      if (state == exec_pkg::ST_IDLE && req) begin
         op_q <= op;
         operand_q <= operand;
         base_q <= base_addr;
      end
   end

   always_ff @(posedge clock) begin
      if (nreset) begin
         state <= exec_pkg::ST_IDLE;
         ack <= 1'b0;
         a <= '0;
         x <= '0;
         y <= '0;
         flags <= '0;
         eff_addr <= '0;
         page_crossed <= 1'b0;
      end else begin
         case (state)
            exec_pkg::ST_IDLE: begin
               if (req) state <= exec_pkg::ST_EXEC;
            end
            exec_pkg::ST_EXEC: begin
               if (is_idx) begin
                  state <= exec_pkg::ST_WAIT_ADDR;
               end else begin
                  // ALU commit, single cycle
                  if (write_a) a <= result;
                  if (write_x) x <= result;
                  if (write_y) y <= result;
                  flags <= flags_next;
                  state <= exec_pkg::ST_DONE;
                  ack <= 1'b1;
               end
            end
            exec_pkg::ST_WAIT_ADDR: begin
               // latency depends on page cross
               if (addr_done) begin
                  eff_addr <= sum_addr;
                  page_crossed <= crossed;
                  state <= exec_pkg::ST_DONE;
                  ack <= 1'b1;
               end
            end
            default: begin
               // hold ack until the requester lets go
               if (!req) begin
                  state <= exec_pkg::ST_IDLE;
                  ack <= 1'b0;
               end
            end
         endcase
      end
   end

endmodule

// ==== hw/exec_unit.sv ====
// Execution unit top level
// ALU, indexed address generator and register commit, wired together

module exec_unit #(
   parameter int DATA_W = exec_pkg::DEFAULT_DATA_W
) (
   input  logic                clock,
   input  logic                nreset,
   input  logic                req,
   input  exec_pkg::op_t       op,
   input  logic [DATA_W-1:0]   operand,
   input  logic [2*DATA_W-1:0] base_addr,
   output logic                ack,
   output logic [DATA_W-1:0]   a,
   output logic [DATA_W-1:0]   x,
   output logic [DATA_W-1:0]   y,
   output logic [7:0]          flags,
   output logic [2*DATA_W-1:0] eff_addr,
   output logic                page_crossed
);

   exec_pkg::op_t       op_q;
   logic [DATA_W-1:0]   operand_q;
   logic [2*DATA_W-1:0] base_q;
   logic [DATA_W-1:0]   result;
   logic [7:0]          flags_next;
   logic                write_a;
   logic                write_x;
   logic                write_y;
   logic                addr_start;
   logic                addr_done;
   logic [2*DATA_W-1:0] sum_addr;
   logic                crossed;

   alu_core #(.DATA_W(DATA_W)) alu_core_i (
      .op(op_q), .operand(operand_q), .a(a), .x(x), .y(y), .flags(flags),
      .result(result), .flags_next(flags_next),
      .write_a(write_a), .write_x(write_x), .write_y(write_y)
   );

   index_addr_gen #(.DATA_W(DATA_W)) index_addr_gen_i (
      .clock(clock), .nreset(nreset), .addr_start(addr_start), .op(op_q),
      .base_addr(base_q), .x(x), .y(y),
      .addr_done(addr_done), .sum_addr(sum_addr), .crossed(crossed)
   );

   register_commit #(.DATA_W(DATA_W)) register_commit_i (
      .clock(clock), .nreset(nreset), .req(req), .op(op), .operand(operand),
      .base_addr(base_addr), .result(result), .flags_next(flags_next),
      .write_a(write_a), .write_x(write_x), .write_y(write_y),
      .addr_done(addr_done), .sum_addr(sum_addr), .crossed(crossed),
      .ack(ack), .op_q(op_q), .operand_q(operand_q), .base_q(base_q),
      .addr_start(addr_start), .a(a), .x(x), .y(y), .flags(flags),
      .eff_addr(eff_addr), .page_crossed(page_crossed)
   );

endmodule

// ==== testbench/exec_model.svh ====
// Reference model of the execution unit
// registers, flags and effective address, updated once per operation

`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

logic [DATA_W-1:0]   m_a;
logic [DATA_W-1:0]   m_x;
logic [DATA_W-1:0]   m_y;
logic [7:0]          m_flags;
logic [2*DATA_W-1:0] m_eff;
logic                m_crossed;

task automatic model_reset();
   m_a = '0;
   m_x = '0;
   m_y = '0;
   m_flags = '0;
   m_eff = '0;
   m_crossed = 1'b0;
endtask

function automatic void update_nz(input logic [DATA_W-1:0] value);
   m_flags[exec_pkg::FLAG_N] = value[DATA_W-1];
   m_flags[exec_pkg::FLAG_Z] = (value == '0);
endfunction

task automatic model_apply(input exec_pkg::op_t op, input logic [DATA_W-1:0] operand,
                           input logic [2*DATA_W-1:0] base);
   int                full;
   int                sgn;
   int                half;
   logic              cbit;
   logic [DATA_W-1:0] diff;
   logic [DATA_W-1:0] index;
   half = 1 << (DATA_W - 1);
   cbit = m_flags[exec_pkg::FLAG_C];
   diff = '0;
   case (op)
      exec_pkg::OP_LDA: m_a = operand;
      exec_pkg::OP_LDX: m_x = operand;
      exec_pkg::OP_LDY: m_y = operand;
      exec_pkg::OP_AND: m_a = m_a & operand;
      exec_pkg::OP_ORA: m_a = m_a | operand;
      exec_pkg::OP_EOR: m_a = m_a ^ operand;
      exec_pkg::OP_INX: m_x = m_x + 1'b1;
      exec_pkg::OP_DEX: m_x = m_x - 1'b1;
      exec_pkg::OP_INY: m_y = m_y + 1'b1;
      exec_pkg::OP_DEY: m_y = m_y - 1'b1;
      exec_pkg::OP_TAX: m_x = m_a;
      exec_pkg::OP_TAY: m_y = m_a;
      exec_pkg::OP_TXA: m_a = m_x;
      exec_pkg::OP_TYA: m_a = m_y;
      exec_pkg::OP_ADC: begin
         full = int'(m_a) + int'(operand) + int'(cbit);
         sgn = int'($signed(m_a)) + int'($signed(operand)) + int'(cbit);
         m_flags[exec_pkg::FLAG_C] = (full >= 2 * half);
         m_flags[exec_pkg::FLAG_V] = (sgn < -half) || (sgn >= half);
         m_a = full[DATA_W-1:0];
      end
      exec_pkg::OP_SBC: begin
         // borrow is the inverted carry
         full = int'(m_a) - int'(operand) - (1 - int'(cbit));
         sgn = int'($signed(m_a)) - int'($signed(operand)) - (1 - int'(cbit));
         m_flags[exec_pkg::FLAG_C] = (full >= 0);
         m_flags[exec_pkg::FLAG_V] = (sgn < -half) || (sgn >= half);
         m_a = full[DATA_W-1:0];
      end
      exec_pkg::OP_CMP: begin
         full = int'(m_a) - int'(operand);
         m_flags[exec_pkg::FLAG_C] = (full >= 0);
         diff = full[DATA_W-1:0];
      end
      exec_pkg::OP_ASL: begin
         m_flags[exec_pkg::FLAG_C] = m_a[DATA_W-1];
         m_a = m_a << 1;
      end
      exec_pkg::OP_LSR: begin
         m_flags[exec_pkg::FLAG_C] = m_a[0];
         m_a = m_a >> 1;
      end
      exec_pkg::OP_ROL: begin
         m_flags[exec_pkg::FLAG_C] = m_a[DATA_W-1];
         m_a = {m_a[DATA_W-2:0], cbit};
      end
      exec_pkg::OP_ROR: begin
         m_flags[exec_pkg::FLAG_C] = m_a[0];
         m_a = {cbit, m_a[DATA_W-1:1]};
      end
      exec_pkg::OP_CLC: m_flags[exec_pkg::FLAG_C] = 1'b0;
      exec_pkg::OP_SEC: m_flags[exec_pkg::FLAG_C] = 1'b1;
      exec_pkg::OP_CLV: m_flags[exec_pkg::FLAG_V] = 1'b0;
      default: begin
         // indexed address, wraps at the top of the address range
         index = (op == exec_pkg::OP_IDX_X) ? m_x : m_y;
         m_eff = base + {{DATA_W{1'b0}}, index};
         m_crossed = (m_eff[2*DATA_W-1:DATA_W] != base[2*DATA_W-1:DATA_W]);
      end
   endcase
   case (op)
      exec_pkg::OP_LDX, exec_pkg::OP_INX, exec_pkg::OP_DEX, exec_pkg::OP_TAX: update_nz(m_x);
      exec_pkg::OP_LDY, exec_pkg::OP_INY, exec_pkg::OP_DEY, exec_pkg::OP_TAY: update_nz(m_y);
      exec_pkg::OP_CMP: update_nz(diff);
      exec_pkg::OP_CLC, exec_pkg::OP_SEC, exec_pkg::OP_CLV: ;
      exec_pkg::OP_IDX_X, exec_pkg::OP_IDX_Y: ;
      default: update_nz(m_a);
   endcase
endtask

`endif

// ==== testbench/tb_exec_unit.sv ====
// Testbench for the execution unit
// clock and reset, random requests over req/ack, checks against the model

module tb_exec_unit;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int DATA_W = exec_pkg::DEFAULT_DATA_W;
   localparam int NUM_OPS = 2000;
   localparam int TIMEOUT = 20;

   logic                clock;
   logic                nreset;
   logic                req;
   exec_pkg::op_t       op;
   logic [DATA_W-1:0]   operand;
   logic [2*DATA_W-1:0] base_addr;
   logic                ack;
   logic [DATA_W-1:0]   a;
   logic [DATA_W-1:0]   x;
   logic [DATA_W-1:0]   y;
   logic [7:0]          flags;
   logic [2*DATA_W-1:0] eff_addr;
   logic                page_crossed;

   exec_pkg::op_t       cur_op;
   logic [DATA_W-1:0]   cur_operand;
   logic [2*DATA_W-1:0] cur_base;
   exec_pkg::state_t    idle_state = exec_pkg::ST_IDLE;
   int                  cycles;
   int                  expect_edges;
   int                  extra;

   `include "exec_model.svh"

   exec_unit #(.DATA_W(DATA_W)) exec_unit_i (
      .clock(clock), .nreset(nreset), .req(req), .op(op), .operand(operand),
      .base_addr(base_addr), .ack(ack), .a(a), .x(x), .y(y), .flags(flags),
      .eff_addr(eff_addr), .page_crossed(page_crossed)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   task automatic report_value(input string msg);
      $display("[FAIL] %0t ns: %s", $time, msg);
      $display("SIMULATION FAILED");
      $fatal(1, "wrong value");
   endtask

   task automatic report_timeout(input string msg);
      $display("Timeout at %0t ns: %s", $time, msg);
      $display("SIMULATION FAILED");
      $fatal(1, "handshake timeout");
   endtask

   task automatic check_outputs();
      assert (a == m_a)
         else report_value($sformatf("%s: A is %h, expected %h", cur_op.name(), a, m_a));
      assert (x == m_x)
         else report_value($sformatf("%s: X is %h, expected %h", cur_op.name(), x, m_x));
      assert (y == m_y)
         else report_value($sformatf("%s: Y is %h, expected %h", cur_op.name(), y, m_y));
      assert (flags == m_flags)
         else report_value($sformatf("%s: flags %b, expected %b", cur_op.name(), flags, m_flags));
      assert (eff_addr == m_eff)
         else report_value($sformatf("%s: eff_addr %h, expected %h", cur_op.name(), eff_addr, m_eff));
      assert (page_crossed == m_crossed)
         else report_value($sformatf("%s: page_crossed %b", cur_op.name(), page_crossed));
   endtask

   // half of the operands are sign and overflow corners
   function automatic logic [DATA_W-1:0] pick_operand();
      case ($urandom_range(0, 7))
         0: return '0;
         1: return {1'b0, {(DATA_W-1){1'b1}}};
         2: return {1'b1, {(DATA_W-1){1'b0}}};
         3: return '1;
         default: return DATA_W'($urandom);
      endcase
   endfunction

   initial begin
      void'($urandom(52115));
      nreset = 1'b1;
      req = 1'b0;
      op = exec_pkg::OP_LDA;
      operand = '0;
      base_addr = '0;
      cur_op = exec_pkg::OP_LDA;
      model_reset();
      repeat (4) @(negedge clock);
      nreset = 1'b0;
      @(negedge clock);
      assert (ack == 1'b0) else report_value("ack is high after reset");
      check_outputs();

      for (int n = 0; n < NUM_OPS; n++) begin
         cur_op = exec_pkg::op_t'($urandom_range(0, int'(exec_pkg::OP_IDX_Y)));
         cur_operand = pick_operand();
         cur_base = (2*DATA_W)'($urandom);
         op = cur_op;
         operand = cur_operand;
         base_addr = cur_base;
         req = 1'b1;
         cycles = 0;
         while (!ack) begin
            @(negedge clock);
            cycles++;
            // request already captured, scramble the inputs
            op = exec_pkg::op_t'($urandom_range(0, int'(exec_pkg::OP_IDX_Y)));
            operand = DATA_W'($urandom);
            base_addr = (2*DATA_W)'($urandom);
            if (cycles > TIMEOUT) begin
               report_timeout($sformatf("ack never rose for %s", cur_op.name()));
            end
         end
         model_apply(cur_op, cur_operand, cur_base);
         if (cur_op == exec_pkg::OP_IDX_X || cur_op == exec_pkg::OP_IDX_Y) begin
            expect_edges = m_crossed ? 4 : 3;
         end else begin
            expect_edges = 2;
         end
         assert (cycles == expect_edges)
            else report_value($sformatf("%s: ack after %0d edges, expected %0d",
                                        cur_op.name(), cycles, expect_edges));
         check_outputs();

         // back-pressure, req held high a little longer
         extra = $urandom_range(0, 5);
         repeat (extra) begin
            @(negedge clock);
            assert (ack) else report_value("ack dropped while req was still high");
            check_outputs();
         end
         req = 1'b0;
         cycles = 0;
         while (ack) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT) begin
               report_timeout($sformatf("ack stayed high, no return to %s", idle_state.name()));
            end
         end
         check_outputs();
      end
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+testbench
hw/exec_pkg.sv
hw/alu_core.sv
hw/index_addr_gen.sv
hw/register_commit.sv
hw/exec_unit.sv
testbench/tb_exec_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execution unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
   --top-module tb_exec_unit -o sim_exec_unit
./obj_dir/sim_exec_unit 2>&1 | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
   echo "run.sh: test passed"
   exit 0
else
   echo "run.sh: test failed, see sim.log"
   exit 1
fi
